// File: logic/exec_pkg.sv
// shared widths, opcodes and request/result structs of the execute stage, used by scoped names
`default_nettype none

package exec_pkg;

    localparam int WORD_W = 32;  // data and address width
    localparam int REG_W  = 5;   // scalar register index
    localparam int MREG_W = 3;   // matrix register index

    // bit positions in the completion vector
    localparam int FU_ALU = 0;
    localparam int FU_SLS = 1;
    localparam int FU_BR  = 2;
    localparam int FU_MLS = 3;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL
    } branch_type_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_type_e;

    typedef struct packed {
        alu_op_e           aluop;
        logic [WORD_W-1:0] port_a;
        logic [WORD_W-1:0] port_b;
    } alu_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] port_output;
        logic              negative;
        logic              overflow;
        logic              zero;
    } alu_res_t;

    typedef struct packed {
        branch_type_e      branch_type;
        logic [WORD_W-1:0] reg_a;
        logic [WORD_W-1:0] reg_b;
        logic [WORD_W-1:0] current_pc;
        logic [WORD_W-1:0] imm;
        logic              predicted_outcome;
    } branch_req_t;

    typedef struct packed {
        logic              branch_outcome;  // 1 = taken
        logic [WORD_W-1:0] branch_target;
        logic [WORD_W-1:0] correct_pc;      // where fetch should be
        logic              misprediction;
        logic              update_btb;
        logic              resolved;        // one-cycle pulse
    } branch_res_t;

    typedef struct packed {
        mem_type_e         mem_type;
        logic [WORD_W-1:0] rs1;   // base
        logic [WORD_W-1:0] rs2;   // store data
        logic [WORD_W-1:0] imm;
        logic [REG_W-1:0]  rd;
    } sls_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] addr;
        logic              ren;
        logic              wen;
        logic [WORD_W-1:0] store;
    } dmem_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] dmemload;
        logic [1:0]        dhit;  // [0] load hit, [1] store hit
        logic [REG_W-1:0]  rd;
    } sls_res_t;

    typedef struct packed {
        logic              ls;      // 1 = store
        logic [MREG_W-1:0] rd;
        logic [WORD_W-1:0] rs;      // base
        logic [WORD_W-1:0] stride;
        logic [WORD_W-1:0] imm;
    } mls_req_t;

    typedef struct packed {
        logic              done;
        logic              ls_out;
        logic [MREG_W-1:0] rd_out;
        logic [WORD_W-1:0] address;
        logic [WORD_W-1:0] stride_out;
    } mls_out_t;

    typedef logic [3:0] fu_ex_t;  // one done bit per unit

endpackage

`default_nettype wire

// File: logic/execute.sv
// execute stage top level; wires the four units to dispatch, memory and scratchpad and builds fu_ex
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire                             CLK,
    input  wire                             rst_n,
    // scalar ALU
    input  wire                             alu_en,
    input  wire exec_pkg::alu_req_t         alu_req,
    input  wire [exec_pkg::REG_W-1:0]       rd,
    // branch
    input  wire                             br_en,
    input  wire exec_pkg::branch_req_t      br_req,
    // scalar load/store
    input  wire                             sls_en,
    input  wire exec_pkg::sls_req_t         sls_req,
    input  wire [exec_pkg::WORD_W-1:0]      dmem_in,
    input  wire                             dhit_in,
    // matrix load/store
    input  wire                             mls_en,
    input  wire exec_pkg::mls_req_t         mls_req,
    input  wire                             mhit,
    // results
    output exec_pkg::alu_res_t              alu_res,
    output logic [exec_pkg::REG_W-1:0]      alu_rd,
    output exec_pkg::branch_res_t           br_res,
    output exec_pkg::dmem_req_t             dmem_req,
    output exec_pkg::sls_res_t              sls_res,
    output exec_pkg::mls_out_t              mls_out,
    output exec_pkg::fu_ex_t                fu_ex
);

    fu_alu alu_i (
        .req (alu_req),
        .res (alu_res)  // to writeback
    );

    fu_branch branch_i (
        .CLK   (CLK),
        .rst_n (rst_n),
        .en    (br_en),
        .req   (br_req),
        .res   (br_res)  // to fetch, scoreboard, writeback
    );

    fu_scalar_ls sls_i (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .en      (sls_en),
        .req     (sls_req),
        .dmem_in (dmem_in),
        .dhit_in (dhit_in),
        .mem     (dmem_req),  // to data memory
        .res     (sls_res)
    );

    fu_matrix_ls mls_i (
        .CLK   (CLK),
        .rst_n (rst_n),
        .en    (mls_en),
        .req   (mls_req),
        .mhit  (mhit),
        .out   (mls_out)  // to scratchpad and scoreboard
    );

    assign alu_rd = rd;  // ALU dest index rides alongside

    // completion vector to scoreboard
    assign fu_ex[exec_pkg::FU_ALU] = alu_en;  // same-cycle result
    assign fu_ex[exec_pkg::FU_SLS] = |sls_res.dhit;
    assign fu_ex[exec_pkg::FU_BR]  = br_res.resolved || br_res.misprediction;
    assign fu_ex[exec_pkg::FU_MLS] = mls_out.done;

endmodule

`default_nettype wire

// File: logic/fu_alu.sv
// combinational scalar ALU; result and flags are valid in the same cycle as the request
`timescale 1ns/1ps
`default_nettype none

module fu_alu (
    input  wire exec_pkg::alu_req_t req,
    output exec_pkg::alu_res_t      res
);

    logic [exec_pkg::WORD_W-1:0] a;
    logic [exec_pkg::WORD_W-1:0] b;
    logic [exec_pkg::WORD_W-1:0] result;
    logic [4:0]                  shamt;
    logic                        ovf;

    assign a     = req.port_a;
    assign b     = req.port_b;
    assign shamt = b[4:0];  // low 5 bits only

    always_comb begin
        ovf = 1'b0;  // only add/sub can overflow
        case (req.aluop)
            exec_pkg::ALU_ADD: begin
                result = a + b;
                ovf    = (a[31] == b[31]) && (result[31] != a[31]);  // same signs in, flip out
            end
            exec_pkg::ALU_SUB: begin
                result = a - b;
                ovf    = (a[31] != b[31]) && (result[31] != a[31]);  // opposite signs in
            end
            exec_pkg::ALU_AND:  result = a & b;
            exec_pkg::ALU_OR:   result = a | b;
            exec_pkg::ALU_XOR:  result = a ^ b;
            exec_pkg::ALU_SLL:  result = a << shamt;
            exec_pkg::ALU_SRL:  result = a >> shamt;
            exec_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);  // sign fill
            exec_pkg::ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            exec_pkg::ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            default:            result = '0;  // unused opcodes
        endcase
    end

    assign res.port_output = result;
    assign res.negative    = result[exec_pkg::WORD_W-1];  // msb of result
    assign res.overflow    = ovf;
    assign res.zero        = (result == '0);

endmodule

`default_nettype wire

// File: logic/fu_branch.sv
// branch resolver; registers outcome, target and misprediction one cycle after the enable strobe
`timescale 1ns/1ps
`default_nettype none

module fu_branch (
    input  wire                        CLK,
    input  wire                        rst_n,
    input  wire                        en,
    input  wire exec_pkg::branch_req_t req,
    output exec_pkg::branch_res_t      res
);

    logic                        taken;
    logic [exec_pkg::WORD_W-1:0] target;
    logic [exec_pkg::WORD_W-1:0] fallthrough;

    logic                        outcome_q;
    logic                        mispredict_q;
    logic                        update_btb_q;
    logic                        resolved_q;
    logic [exec_pkg::WORD_W-1:0] target_q;
    logic [exec_pkg::WORD_W-1:0] correct_pc_q;

    // condition evaluation
    always_comb begin
        case (req.branch_type)
            exec_pkg::BR_BEQ:  taken = (req.reg_a == req.reg_b);
            exec_pkg::BR_BNE:  taken = (req.reg_a != req.reg_b);
            exec_pkg::BR_BLT:  taken = ($signed(req.reg_a) < $signed(req.reg_b));
            exec_pkg::BR_BGE:  taken = ($signed(req.reg_a) >= $signed(req.reg_b));
            exec_pkg::BR_BLTU: taken = (req.reg_a < req.reg_b);
            exec_pkg::BR_BGEU: taken = (req.reg_a >= req.reg_b);
            exec_pkg::BR_JAL:  taken = 1'b1;  // unconditional
            default:           taken = 1'b0;
        endcase
    end

    assign target      = req.current_pc + req.imm;  // pc-relative
    assign fallthrough = req.current_pc + 32'd4;    // next sequential

    // flags live for one cycle per strobe
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            outcome_q    <= 1'b0;
            mispredict_q <= 1'b0;
            update_btb_q <= 1'b0;
            resolved_q   <= 1'b0;
        end else begin
            outcome_q    <= en && taken;
            mispredict_q <= en && (taken != req.predicted_outcome);
            update_btb_q <= en && taken;  // btb learns taken branches
            resolved_q   <= en;
        end
    end

    always_ff @(posedge CLK) begin
        if (en) begin
            target_q     <= target;
            correct_pc_q <= taken ? target : fallthrough;
        end
    end

    assign res.branch_outcome = outcome_q;
    assign res.branch_target  = target_q;
    assign res.correct_pc     = correct_pc_q;
    assign res.misprediction  = mispredict_q;  // to fetch and scoreboard
    assign res.update_btb     = update_btb_q;
    assign res.resolved       = resolved_q;

endmodule

`default_nettype wire

// File: logic/fu_matrix_ls.sv
// matrix load/store unit; keeps a scratchpad row-block request live until mhit, then pulses done
`timescale 1ns/1ps
`default_nettype none

module fu_matrix_ls (
    input  wire                     CLK,
    input  wire                     rst_n,
    input  wire                     en,
    input  wire exec_pkg::mls_req_t req,
    input  wire                     mhit,
    output exec_pkg::mls_out_t      out
);

    logic                        busy;
    logic                        done_q;
    logic                        accept;
    logic                        ls_q;
    logic [exec_pkg::MREG_W-1:0] rd_q;
    logic [exec_pkg::WORD_W-1:0] addr_q;
    logic [exec_pkg::WORD_W-1:0] stride_q;

    assign accept = en && !busy;  // strobe while busy is dropped

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= busy && mhit;  // one pulse after the hit
            if (accept) begin
                busy <= 1'b1;
            end else if (mhit) begin
                busy <= 1'b0;  // scratchpad took it
            end
        end
    end

    // latched request
    always_ff @(posedge CLK) begin
        if (accept) begin
            ls_q     <= req.ls;
            rd_q     <= req.rd;
            addr_q   <= req.rs + req.imm;  // scratchpad base
            stride_q <= req.stride;
        end
    end

    assign out.done       = done_q;  // to scoreboard
    assign out.ls_out     = busy && ls_q;  // low when idle
    assign out.rd_out     = rd_q;
    assign out.address    = addr_q;
    assign out.stride_out = stride_q;

endmodule

`default_nettype wire

// File: logic/fu_scalar_ls.sv
// scalar load/store unit; holds a data-memory request until the hit, then pulses dhit once
`timescale 1ns/1ps
`default_nettype none

module fu_scalar_ls (
    input  wire                             CLK,
    input  wire                             rst_n,
    input  wire                             en,
    input  wire exec_pkg::sls_req_t         req,
    input  wire [exec_pkg::WORD_W-1:0]      dmem_in,
    input  wire                             dhit_in,
    output exec_pkg::dmem_req_t             mem,
    output exec_pkg::sls_res_t              res
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e                      state;
    logic                        accept;
    logic                        hit;
    logic                        is_load_q;
    logic                        is_store_q;
    logic [exec_pkg::WORD_W-1:0] addr_q;
    logic [exec_pkg::WORD_W-1:0] store_q;
    logic [exec_pkg::REG_W-1:0]  rd_q;
    logic [1:0]                  dhit_q;
    logic [exec_pkg::WORD_W-1:0] load_q;
    logic [exec_pkg::REG_W-1:0]  rd_out_q;

    assign accept = (state == IDLE) && en && (req.mem_type != exec_pkg::MEM_NONE);  // busy drops en
    assign hit    = (state == BUSY) && dhit_in;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state  <= IDLE;
            dhit_q <= 2'b00;
        end else begin
            dhit_q <= 2'b00;  // single-cycle pulse
            case (state)
                IDLE: if (accept) state <= BUSY;
                BUSY: begin
                    if (dhit_in) begin
                        state  <= IDLE;
                        dhit_q <= {is_store_q, is_load_q};  // type bit
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q     <= req.rs1 + req.imm;  // effective address
            store_q    <= req.rs2;
            rd_q       <= req.rd;
            is_load_q  <= (req.mem_type == exec_pkg::MEM_LOAD);
            is_store_q <= (req.mem_type == exec_pkg::MEM_STORE);
        end
    end

    // result payload captured on the hit
    always_ff @(posedge CLK) begin
        if (hit) begin
            load_q   <= dmem_in;
            rd_out_q <= rd_q;
        end
    end

    assign mem.addr  = addr_q;
    assign mem.ren   = (state == BUSY) && is_load_q;   // held until hit
    assign mem.wen   = (state == BUSY) && is_store_q;
    assign mem.store = store_q;

    assign res.dmemload = load_q;
    assign res.dhit     = dhit_q;
    assign res.rd       = rd_out_q;  // to writeback

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator, run it, and grade the run by its log
rm -f sim.log
verilator --binary --timing -f src.f --top-module execute_tb --Mdir obj_dir -o execute_sim \
    && ./obj_dir/execute_sim | tee sim.log \
    && grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim/execute_ref.svh
// reference models of the execute stage rules, included inside the testbench module
`ifndef EXECUTE_REF_SVH
`define EXECUTE_REF_SVH

// exact signed arithmetic in 64 bits, result is the low word
function automatic exec_pkg::alu_res_t ref_alu(exec_pkg::alu_req_t req);
    exec_pkg::alu_res_t r;
    longint             sa;
    longint             sb;
    longint             sr;  // true result before truncation
    logic [4:0]         sh;
    sa = longint'($signed(req.port_a));
    sb = longint'($signed(req.port_b));
    sh = req.port_b[4:0];  // shift amount from low bits
    sr = '0;
    r  = '0;
    case (req.aluop)
        exec_pkg::ALU_ADD:  sr = sa + sb;
        exec_pkg::ALU_SUB:  sr = sa - sb;
        exec_pkg::ALU_AND:  sr = sa & sb;
        exec_pkg::ALU_OR:   sr = sa | sb;
        exec_pkg::ALU_XOR:  sr = sa ^ sb;
        exec_pkg::ALU_SLL:  sr = {32'd0, req.port_a << sh};
        exec_pkg::ALU_SRL:  sr = {32'd0, req.port_a >> sh};
        exec_pkg::ALU_SRA:  sr = sa >>> sh;  // sign comes from the 64-bit value
        exec_pkg::ALU_SLT:  sr = (sa < sb) ? 64'sd1 : 64'sd0;
        exec_pkg::ALU_SLTU: sr = (req.port_a < req.port_b) ? 64'sd1 : 64'sd0;
        default:            sr = '0;
    endcase
    r.port_output = sr[31:0];
    // bit 32 of the exact sum disagrees with bit 31 on signed overflow
    r.overflow = ((req.aluop == exec_pkg::ALU_ADD) || (req.aluop == exec_pkg::ALU_SUB))
                 && (sr[32] != sr[31]);
    r.zero     = (r.port_output == 32'd0);
    r.negative = r.port_output[31];
    return r;
endfunction

function automatic exec_pkg::branch_res_t ref_branch(exec_pkg::branch_req_t req);
    exec_pkg::branch_res_t r;
    longint                sa;
    longint                sb;
    logic                  taken;
    sa = longint'($signed(req.reg_a));
    sb = longint'($signed(req.reg_b));
    case (req.branch_type)
        exec_pkg::BR_BEQ:  taken = (sa == sb);
        exec_pkg::BR_BNE:  taken = (sa != sb);
        exec_pkg::BR_BLT:  taken = (sa < sb);
        exec_pkg::BR_BGE:  taken = !(sa < sb);
        exec_pkg::BR_BLTU: taken = (req.reg_a < req.reg_b);
        exec_pkg::BR_BGEU: taken = !(req.reg_a < req.reg_b);
        exec_pkg::BR_JAL:  taken = 1'b1;
        default:           taken = 1'b0;
    endcase
    r.branch_outcome = taken;
    r.branch_target  = req.current_pc + req.imm;
    r.correct_pc     = taken ? r.branch_target : req.current_pc + 32'd4;
    r.misprediction  = taken ^ req.predicted_outcome;
    r.update_btb     = taken;
    r.resolved       = 1'b1;  // pulse seen one cycle after the strobe
    return r;
endfunction

// base plus offset, shared by both load/store units
function automatic logic [31:0] ref_ea(logic [31:0] base, logic [31:0] offset);
    return base + offset;
endfunction

function automatic exec_pkg::dmem_req_t ref_dmem(exec_pkg::sls_req_t req);
    exec_pkg::dmem_req_t m;
    m.addr  = ref_ea(req.rs1, req.imm);
    m.ren   = (req.mem_type == exec_pkg::MEM_LOAD);
    m.wen   = (req.mem_type == exec_pkg::MEM_STORE);
    m.store = req.rs2;
    return m;
endfunction

// live scratchpad request while the unit waits for mhit
function automatic exec_pkg::mls_out_t ref_mls_live(exec_pkg::mls_req_t req);
    exec_pkg::mls_out_t o;
    o.done       = 1'b0;
    o.ls_out     = req.ls;
    o.rd_out     = req.rd;
    o.address    = ref_ea(req.rs, req.imm);
    o.stride_out = req.stride;
    return o;
endfunction

`endif

// File: sim/execute_tb.sv
// execute stage testbench; random stimulus, memory and scratchpad models, reference checks
`timescale 1ns/1ps
`default_nettype none

module execute_tb;

    logic                        CLK;
    logic                        rst_n;
    logic                        alu_en;
    exec_pkg::alu_req_t          alu_req;
    logic [exec_pkg::REG_W-1:0]  rd;
    logic                        br_en;
    exec_pkg::branch_req_t       br_req;
    logic                        sls_en;
    exec_pkg::sls_req_t          sls_req;
    logic [exec_pkg::WORD_W-1:0] dmem_in;
    logic                        dhit_in;
    logic                        mls_en;
    exec_pkg::mls_req_t          mls_req;
    logic                        mhit;
    exec_pkg::alu_res_t          alu_res;
    logic [exec_pkg::REG_W-1:0]  alu_rd;
    exec_pkg::branch_res_t       br_res;
    exec_pkg::dmem_req_t         dmem_req;
    exec_pkg::sls_res_t          sls_res;
    exec_pkg::mls_out_t          mls_out;
    exec_pkg::fu_ex_t            fu_ex;

    logic [exec_pkg::WORD_W-1:0] hit_data;     // word returned with the last hit
    int unsigned                 stall_extra;  // extra hit latency, overlap test only
    int unsigned                 errors;
    int unsigned                 tests_passed;
    int unsigned                 tests_failed;

    `include "execute_ref.svh"

    execute execute_i (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;  // 8 ns
    end

    // data memory, hit 0 to 5 cycles after the strobe shows up
    initial begin : mem_model
        int unsigned delay;
        dhit_in  = 1'b0;
        dmem_in  = '0;
        hit_data = '0;
        forever begin
            @(posedge CLK);
            #1;
            dhit_in = 1'b0;
            if (dmem_req.ren || dmem_req.wen) begin
                delay = $urandom_range(5, 0) + stall_extra;
                repeat (delay) begin
                    @(posedge CLK);
                    #1;
                end
                dmem_in  = $urandom;
                hit_data = dmem_in;
                dhit_in  = 1'b1;  // seen at the next edge
            end
        end
    end

    // scratchpad, triggered by the accepted strobe
    initial begin : spad_model
        int unsigned delay;
        mhit = 1'b0;
        forever begin
            @(posedge CLK);
            if (mls_en) begin
                #1;
                delay = $urandom_range(5, 0) + stall_extra;
                repeat (delay) begin
                    @(posedge CLK);
                    #1;
                end
                mhit = 1'b1;
                @(posedge CLK);
                #1;
                mhit = 1'b0;
            end
        end
    end

    task automatic next_cycle();
        @(posedge CLK);
        #1;  // drive and sample just after the edge
    endtask

    task automatic idle_inputs();
        alu_en  = 1'b0;
        alu_req = '0;
        rd      = '0;
        br_en   = 1'b0;
        br_req  = '0;
        sls_en  = 1'b0;
        sls_req = '0;
        mls_en  = 1'b0;
        mls_req = '0;
    endtask

    task automatic check_alu(exec_pkg::alu_res_t got, exec_pkg::alu_res_t exp,
                             logic [4:0] got_rd, logic [4:0] exp_rd, string what);
        if (got !== exp || got_rd !== exp_rd) begin
            errors++;
            $display("[FAIL] %0t %s: got %h rd %0d, expected %h rd %0d", $time, what, got,
                     got_rd, exp, exp_rd);
        end
    endtask

    task automatic check_branch(exec_pkg::branch_res_t got, exec_pkg::branch_res_t exp,
                                string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_dmem(exec_pkg::dmem_req_t got, exec_pkg::dmem_req_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sls(exec_pkg::sls_res_t got, exec_pkg::sls_res_t exp, logic with_data,
                             string what);
        exec_pkg::sls_res_t cmp;
        cmp = exp;
        if (!with_data) cmp.dmemload = got.dmemload;  // store data return is don't care
        if (got !== cmp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, cmp);
        end
    endtask

    task automatic check_mls(exec_pkg::mls_out_t got, exec_pkg::mls_out_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_fu_ex(exec_pkg::fu_ex_t got, exec_pkg::fu_ex_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(string name, int unsigned start);
        if (errors == start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - start);
        end
    endtask

    function automatic exec_pkg::alu_req_t rand_alu_req();
        exec_pkg::alu_req_t r;
        r.aluop  = exec_pkg::alu_op_e'(4'($urandom_range(9, 0)));
        r.port_a = $urandom;
        r.port_b = ($urandom_range(7, 0) == 0) ? r.port_a : $urandom;  // hits zero results
        return r;
    endfunction

    function automatic exec_pkg::branch_req_t rand_br_req();
        exec_pkg::branch_req_t r;
        r.branch_type       = exec_pkg::branch_type_e'(3'($urandom_range(6, 0)));
        r.reg_a             = $urandom;
        r.reg_b             = ($urandom_range(3, 0) == 0) ? r.reg_a : $urandom;
        r.current_pc        = $urandom & 32'hffff_fffc;
        r.imm               = $urandom & 32'h0000_1ffc;
        if (r.imm[12]) r.imm = r.imm | 32'hffff_e000;  // backward offsets too
        r.predicted_outcome = 1'($urandom);
        return r;
    endfunction

    function automatic exec_pkg::sls_req_t rand_sls_req();
        exec_pkg::sls_req_t r;
        r.mem_type = ($urandom_range(1, 0) == 0) ? exec_pkg::MEM_LOAD : exec_pkg::MEM_STORE;
        r.rs1      = $urandom;
        r.rs2      = $urandom;
        r.imm      = $urandom & 32'h0000_0fff;
        r.rd       = 5'($urandom);
        return r;
    endfunction

    function automatic exec_pkg::mls_req_t rand_mls_req();
        exec_pkg::mls_req_t r;
        r.ls     = 1'($urandom);
        r.rd     = 3'($urandom);
        r.rs     = $urandom;
        r.stride = $urandom & 32'h0000_00ff;
        r.imm    = $urandom & 32'h0000_0fff;
        return r;
    endfunction

    task automatic test_reset();
        int unsigned start;
        start = errors;
        check_fu_ex(fu_ex, '0, "fu_ex after reset");
        check_flag(dmem_req.ren, 1'b0, "ren after reset");
        check_flag(dmem_req.wen, 1'b0, "wen after reset");
        check_flag(mls_out.done, 1'b0, "done after reset");
        check_flag(mls_out.ls_out, 1'b0, "matrix request after reset");
        check_flag(br_res.resolved, 1'b0, "resolved after reset");
        check_flag(br_res.misprediction, 1'b0, "misprediction after reset");
        report_test("reset state", start);
    endtask

    task automatic test_alu();
        int unsigned start;
        start = errors;
        repeat (200) begin
            next_cycle();
            alu_en  = 1'b1;
            alu_req = rand_alu_req();
            rd      = 5'($urandom);
            #1;  // combinational, same cycle
            check_alu(alu_res, ref_alu(alu_req), alu_rd, rd, "alu result");
            check_flag(fu_ex[0], 1'b1, "fu_ex[0] with alu_en");
            next_cycle();
            alu_en = 1'b0;
            #1;
            check_flag(fu_ex[0], 1'b0, "fu_ex[0] without alu_en");
        end
        report_test("alu", start);
    endtask

    task automatic test_branch();
        exec_pkg::branch_res_t exp;
        int unsigned           start;
        start = errors;
        repeat (200) begin
            next_cycle();
            br_en  = 1'b1;
            br_req = rand_br_req();
            exp    = ref_branch(br_req);
            next_cycle();
            br_en = 1'b0;
            check_branch(br_res, exp, "branch result");
            check_flag(fu_ex[2], 1'b1, "fu_ex[2] after branch");
        end
        report_test("branch", start);
    endtask

    task automatic run_sls(exec_pkg::sls_req_t req);
        exec_pkg::sls_res_t exp;
        int unsigned        n;
        sls_en  = 1'b1;
        sls_req = req;
        next_cycle();
        sls_en = 1'b0;
        n      = 0;
        while (sls_res.dhit == 2'b00 && n < 20) begin
            check_dmem(dmem_req, ref_dmem(req), "scalar request held");
            next_cycle();
            n++;
        end
        if (sls_res.dhit == 2'b00) begin
            errors++;
            $display("timeout: the scalar load/store unit gave no hit pulse within 20 cycles");
        end else begin
            exp.dmemload = hit_data;
            exp.dhit     = {req.mem_type == exec_pkg::MEM_STORE,
                            req.mem_type == exec_pkg::MEM_LOAD};
            exp.rd       = req.rd;
            check_sls(sls_res, exp, req.mem_type == exec_pkg::MEM_LOAD, "scalar result");
            check_flag(fu_ex[1], 1'b1, "fu_ex[1] with dhit");
            next_cycle();
            check_flag(|sls_res.dhit, 1'b0, "single dhit pulse");
        end
    endtask

    task automatic run_mls(exec_pkg::mls_req_t req);
        int unsigned n;
        mls_en  = 1'b1;
        mls_req = req;
        next_cycle();
        mls_en = 1'b0;
        n      = 0;
        while (!mls_out.done && n < 20) begin
            check_mls(mls_out, ref_mls_live(req), "matrix request held");
            next_cycle();
            n++;
        end
        if (!mls_out.done) begin
            errors++;
            $display("timeout: the matrix load/store unit gave no done pulse within 20 cycles");
        end else begin
            check_flag(fu_ex[3], 1'b1, "fu_ex[3] with done");
            check_flag(mls_out.ls_out, 1'b0, "matrix request dropped after hit");
            next_cycle();
            check_flag(mls_out.done, 1'b0, "single done pulse");
        end
    endtask

    task automatic test_overlap();
        exec_pkg::sls_req_t    s_req;
        exec_pkg::sls_res_t    s_exp;
        exec_pkg::mls_req_t    m_req;
        exec_pkg::branch_res_t b_exp;
        logic                  sls_seen;
        logic                  mls_seen;
        int unsigned           n;
        int unsigned           start;
        start       = errors;
        stall_extra = 4;  // keeps both units busy across the other strobes
        s_req       = rand_sls_req();
        m_req       = rand_mls_req();
        sls_en      = 1'b1;
        sls_req     = s_req;
        mls_en      = 1'b1;
        mls_req     = m_req;
        next_cycle();
        mls_en  = 1'b0;
        sls_req = rand_sls_req();  // second strobe while busy
        alu_en  = 1'b1;
        alu_req = rand_alu_req();
        rd      = 5'($urandom);
        br_en   = 1'b1;
        br_req  = rand_br_req();
        b_exp   = ref_branch(br_req);
        #1;
        check_alu(alu_res, ref_alu(alu_req), alu_rd, rd, "overlap alu result");
        next_cycle();
        idle_inputs();
        check_branch(br_res, b_exp, "overlap branch result");
        check_flag(fu_ex[2], 1'b1, "overlap fu_ex[2]");
        sls_seen = 1'b0;
        mls_seen = 1'b0;
        n        = 0;
        while (!(sls_seen && mls_seen) && n < 30) begin
            if (sls_res.dhit != 2'b00) begin
                if (sls_seen) begin
                    errors++;
                    $display("a second dhit pulse came from the ignored scalar strobe");
                end
                sls_seen       = 1'b1;
                s_exp.dmemload = hit_data;
                s_exp.dhit     = {s_req.mem_type == exec_pkg::MEM_STORE,
                                  s_req.mem_type == exec_pkg::MEM_LOAD};
                s_exp.rd       = s_req.rd;
                check_sls(sls_res, s_exp, s_req.mem_type == exec_pkg::MEM_LOAD,
                          "overlap scalar result");
            end else if (!sls_seen) begin
                check_dmem(dmem_req, ref_dmem(s_req), "overlap scalar request held");
            end
            if (mls_out.done) begin
                mls_seen = 1'b1;
            end else if (!mls_seen) begin
                check_mls(mls_out, ref_mls_live(m_req), "overlap matrix request held");
            end
            next_cycle();
            n++;
        end
        if (!(sls_seen && mls_seen)) begin
            errors++;
            $display("timeout: a load/store unit did not finish during the overlap test");
        end
        repeat (3) begin
            check_flag(|sls_res.dhit, 1'b0, "no further dhit pulse");
            check_flag(mls_out.done, 1'b0, "no further done pulse");
            next_cycle();
        end
        stall_extra = 0;
        report_test("overlap", start);
    endtask

    initial begin : main
        int unsigned start;
        void'($urandom(32'hb7bdae47));
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        stall_extra  = 0;
        rst_n        = 1'b0;
        idle_inputs();
        repeat (16) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        next_cycle();
        test_reset();
        test_alu();
        test_branch();
        start = errors;
        repeat (40) run_sls(rand_sls_req());
        report_test("scalar load/store", start);
        start = errors;
        repeat (40) run_mls(rand_mls_req());
        report_test("matrix load/store", start);
        test_overlap();
        $display("tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
                 errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+sim
logic/exec_pkg.sv
logic/fu_alu.sv
logic/fu_branch.sv
logic/fu_scalar_ls.sv
logic/fu_matrix_ls.sv
logic/execute.sv
sim/execute_tb.sv
